//--- flist.f
mby_igr_pkg.sv
igr_epl_shim_ctl.sv
igr_epl_shim_seg.sv
igr_epl_shim_segs.sv
igr_epl_shim.sv
igr_epl_shim_checker.sv
igr_epl_shim_mon.sv
tb_igr_epl_shim.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ingress shim testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_igr_epl_shim -f flist.f -Mdir obj_dir
./obj_dir/Vtb_igr_epl_shim | tee sim.log
if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  exit 1
fi
exit 0

//--- tb_igr_epl_shim.sv
// testbench top for the ingress shim, sends directed and random packets and prints the verdict
`default_nettype none
`timescale 1ns/10ps

module tb_igr_epl_shim;
  import mby_igr_pkg::*;

  // packets per test phase, the aborted packet of the reset phase counted once
  localparam int N_FULL     = 6;
  localparam int N_STRADDLE = 4;
  localparam int N_SHORT    = 14;
  localparam int N_RAND     = 60;
  localparam int N_AFTER    = 5;
  localparam int N_PKTS     = N_FULL + N_STRADDLE + N_SHORT + N_RAND + 1 + N_AFTER;
  localparam int TIMEOUT    = N_PKTS * 20 + 100;

  logic                              cclk;
  logic                              i_reset;
  logic                              i_rx_v;
  logic                              i_rx_sop;
  logic                              i_rx_eop;
  logic [CNT_W-1:0]                  i_rx_nw;
  data64_t [N_LANES-1:0]             i_rx_data;
  epl_ts_t                           i_rx_ts;
  data64_t [N_SEGS-1:0][N_LANES-1:0] o_pb_data;
  seg_md_t [N_SEGS-1:0]              o_pb_md;
  logic [N_SEGS-1:0]                 o_pb_v;

  // monitor status
  logic done;
  int   pending;
  int   err_data;
  int   err_md;
  int   err_time;
  int   err_other;
  int   seed = 32'h075f_ef84;
  int   cycle_cnt;

  igr_epl_shim i_dut (
    .cclk      (cclk),
    .i_reset   (i_reset),
    .i_rx_v    (i_rx_v),
    .i_rx_sop  (i_rx_sop),
    .i_rx_eop  (i_rx_eop),
    .i_rx_nw   (i_rx_nw),
    .i_rx_data (i_rx_data),
    .i_rx_ts   (i_rx_ts),
    .o_pb_data (o_pb_data),
    .o_pb_md   (o_pb_md),
    .o_pb_v    (o_pb_v)
  );

  igr_epl_shim_mon u_mon (
    .cclk        (cclk),
    .i_reset     (i_reset),
    .i_rx_v      (i_rx_v),
    .i_rx_sop    (i_rx_sop),
    .i_rx_eop    (i_rx_eop),
    .i_rx_nw     (i_rx_nw),
    .i_rx_data   (i_rx_data),
    .i_rx_ts     (i_rx_ts),
    .i_pb_data   (o_pb_data),
    .i_pb_md     (o_pb_md),
    .i_pb_v      (o_pb_v),
    .i_done      (done),
    .o_pending   (pending),
    .o_err_data  (err_data),
    .o_err_md    (err_md),
    .o_err_time  (err_time),
    .o_err_other (err_other)
  );

  initial begin
    cclk = 1'b0;
    forever #4 cclk = ~cclk;
  end

  // uniform pick in lo to hi from the seeded stream
  function automatic int pick(input int lo, input int hi);
    int r;
    r = $random(seed);
    pick = lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------

  // one input cycle on the falling edge, data and timestamp are fresh every cycle
  task automatic drive_cycle(input logic v, input logic sop, input logic eop, input int nw);
    @(negedge cclk);
    i_rx_v   = v;
    i_rx_sop = sop;
    i_rx_eop = eop;
    i_rx_nw  = CNT_W'(nw);
    for (int l = 0; l < N_LANES; l++) begin
      i_rx_data[l] = {$random(seed), $random(seed)};
    end
    i_rx_ts = $random(seed);
  endtask

  // step of zero means a random word count per cycle
  task automatic send_packet(input int len, input int step, input logic gaps);
    int rem;
    int nw;
    rem = len;
    while (rem > 0) begin
      nw = (step > 0) ? step : pick(1, N_LANES);
      if (nw > rem) begin
        nw = rem;
      end
      drive_cycle(1'b1, rem == len, nw == rem, nw);
      rem = rem - nw;
      // idle cycle inside the packet moves the timestamp on
      if (gaps && rem > 0 && pick(0, 2) == 0) begin
        drive_cycle(1'b0, 1'b0, 1'b0, 0);
      end
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin : stimulus
    int drain;
    i_reset   = 1'b1;
    i_rx_v    = 1'b0;
    i_rx_sop  = 1'b0;
    i_rx_eop  = 1'b0;
    i_rx_nw   = '0;
    i_rx_data = '0;
    i_rx_ts   = '0;
    done      = 1'b0;
    repeat (8) @(negedge cclk);
    i_reset = 1'b0;

    // full rate, one segment per cycle rotating 0, 1, 2
    for (int p = 0; p < N_FULL; p++) begin
      send_packet(8 * (1 + p % 3), N_LANES, 1'b0);
    end
    // spills into the next segment, three of them close two segments in one cycle
    send_packet(11, 6, 1'b0);
    send_packet(14, 7, 1'b0);
    send_packet(20, 7, 1'b0);
    send_packet(13, 5, 1'b0);

    // the phases above use 21 segments, so this packet fills segment 0 and spills into 1
    // the second cycle closes segment 0 and the reset must swallow its pulse
    drive_cycle(1'b1, 1'b1, 1'b0, 5);
    drive_cycle(1'b1, 1'b0, 1'b0, 6);
    drive_cycle(1'b0, 1'b0, 1'b0, 0);
    i_reset = 1'b1;
    repeat (4) @(negedge cclk);
    i_reset = 1'b0;
    // quiet cycles where no pulse may appear
    repeat (6) drive_cycle(1'b0, 1'b0, 1'b0, 0);
    for (int p = 0; p < N_AFTER; p++) begin
      send_packet(pick(1, 20), 0, 1'b1);
    end

    // single cycle packets with sop and eop in the same segment
    for (int p = 0; p < N_SHORT; p++) begin
      send_packet(1 + p % 7, 1 + p % 7, 1'b0);
    end
    for (int p = 0; p < N_RAND; p++) begin
      send_packet(pick(1, 24), 0, 1'b1);
      if (pick(0, 3) == 0) begin
        drive_cycle(1'b0, 1'b0, 1'b0, 0);
      end
    end
    drive_cycle(1'b0, 1'b0, 1'b0, 0);

    // every pulse is due two cycles after its input cycle
    drain = 0;
    while (pending != 0 && drain < 8) begin
      @(negedge cclk);
      drain++;
    end
    done = 1'b1;
    repeat (2) @(negedge cclk);
    $display("errors: data %0d, metadata %0d, timing %0d, other %0d, assertions %0d",
             err_data, err_md, err_time, err_other, i_dut.u_ctl.u_chk.fail_cnt);
    if (err_data + err_md + err_time + err_other + i_dut.u_ctl.u_chk.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // run limit from the packet count
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge cclk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("errors: data %0d, metadata %0d, timing %0d, other %0d, assertions %0d",
             err_data, err_md, err_time, err_other, i_dut.u_ctl.u_chk.fail_cnt);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- igr_epl_shim_mon.sv
// ingress shim monitor, rebuilds the expected segments from the input cycles and checks each pulse
`default_nettype none
`timescale 1ns/10ps

module igr_epl_shim_mon (
  input  logic                                             cclk,
  input  logic                                             i_reset,
  input  logic                                             i_rx_v,
  input  logic                                             i_rx_sop,
  input  logic                                             i_rx_eop,
  input  logic [mby_igr_pkg::CNT_W-1:0]                    i_rx_nw,
  input  mby_igr_pkg::data64_t [mby_igr_pkg::N_LANES-1:0]   i_rx_data,
  input  mby_igr_pkg::epl_ts_t                             i_rx_ts,
  input  mby_igr_pkg::data64_t [mby_igr_pkg::N_SEGS-1:0][mby_igr_pkg::N_LANES-1:0] i_pb_data,
  input  mby_igr_pkg::seg_md_t [mby_igr_pkg::N_SEGS-1:0]   i_pb_md,
  input  logic [mby_igr_pkg::N_SEGS-1:0]                   i_pb_v,
  input  logic                                             i_done,
  output int                                               o_pending,
  output int                                               o_err_data,
  output int                                               o_err_md,
  output int                                               o_err_time,
  output int                                               o_err_other
);
  import mby_igr_pkg::*;

  // one expected segment and the cycle its pulse is due
  typedef struct packed {
    data64_t [N_LANES-1:0] data;
    seg_md_t               md;
    int                    due;
  } grp_t;

  grp_t exp_q[N_SEGS][$];
  grp_t cur;
  logic open = 1'b0;
  logic done_seen = 1'b0;
  int   cur_seg = 0;
  int   cyc = 0;
  int   n_pending = 0;
  int   err_data = 0;
  int   err_md = 0;
  int   err_time = 0;
  int   err_other = 0;

  assign o_pending   = n_pending;
  assign o_err_data  = err_data;
  assign o_err_md    = err_md;
  assign o_err_time  = err_time;
  assign o_err_other = err_other;

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // packet words are cut into groups of eight and the last group closes at end of packet
  function automatic void ref_cycle(input logic sop, input logic eop, input int nw,
                                    input data64_t [N_LANES-1:0] data, input epl_ts_t ts);
    logic last;
    // a packet that never ended leaves its segment behind
    if (sop && open) begin
      open    = 1'b0;
      cur_seg = (cur_seg + 1) % N_SEGS;
    end
    for (int w = 0; w < nw; w++) begin
      last = eop && (w == nw - 1);
      if (!open) begin
        open       = 1'b1;
        cur        = '0;
        cur.md.sop = sop && (w == 0);
        cur.md.ts  = ts;
      end
      cur.data[cur.md.cnt[2:0]] = data[w];
      cur.md.cnt = cur.md.cnt + 1'b1;
      if (cur.md.cnt == CNT_W'(N_LANES) || last) begin
        cur.md.eop = last;
        // control registers at this edge, the bank raises the valid one edge later
        cur.due    = cyc + 1;
        exp_q[cur_seg].push_back(cur);
        n_pending++;
        cur_seg = (cur_seg + 1) % N_SEGS;
        open    = 1'b0;
      end
    end
  endfunction

  // inputs are stable at the rising edge, the partial state is lost on reset
  always @(posedge cclk) begin
    cyc = cyc + 1;
    if (i_reset) begin
      for (int g = 0; g < N_SEGS; g++) begin
        exp_q[g].delete();
      end
      n_pending = 0;
      cur_seg   = 0;
      open      = 1'b0;
    end else if (i_rx_v) begin
      ref_cycle(i_rx_sop, i_rx_eop, int'(i_rx_nw), i_rx_data, i_rx_ts);
    end
  end

  // ----------------------------------------
  // comparison
  // ----------------------------------------

  task automatic check_seg(input int g, input grp_t grp);
    if (grp.due != cyc) begin
      $display("[FAIL] %0t o_pb_v[%0d] cycle: got %0d, expected %0d", $time, g, cyc, grp.due);
      err_time++;
    end
    if (i_pb_md[g] !== grp.md) begin
      $display("[FAIL] %0t o_pb_md[%0d]: got %h, expected %h", $time, g, i_pb_md[g], grp.md);
      err_md++;
    end
    for (int s = 0; s < int'(grp.md.cnt); s++) begin
      if (i_pb_data[g][s] !== grp.data[s]) begin
        $display("[FAIL] %0t o_pb_data[%0d][%0d]: got %h, expected %h",
                 $time, g, s, i_pb_data[g][s], grp.data[s]);
        err_data++;
      end
    end
  endtask

  // outputs only move at the rising edge, so the falling edge sees them settled
  always @(negedge cclk) begin
    grp_t grp;
    for (int g = 0; g < N_SEGS; g++) begin
      if (i_pb_v[g] === 1'b1) begin
        if (exp_q[g].size() == 0) begin
          $display("%0t: o_pb_v[%0d] pulsed but no segment was expected there", $time, g);
          err_other++;
        end else begin
          grp = exp_q[g].pop_front();
          n_pending--;
          check_seg(g, grp);
        end
      end
    end
    if (i_done && !done_seen) begin
      done_seen = 1'b1;
      for (int g = 0; g < N_SEGS; g++) begin
        if (exp_q[g].size() != 0) begin
          $display("%0d expected segment(s) in slot %0d never got an o_pb_v pulse",
                   exp_q[g].size(), g);
          err_other += exp_q[g].size();
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- igr_epl_shim_checker.sv
// concurrent assertions on the ingress shim control strobes, bound into every control instance
`default_nettype none
`timescale 1ns/10ps

module igr_epl_shim_checker (
  input logic                                                     cclk,
  input logic                                                     i_reset,
  input logic                                                     i_rx_v,
  input logic [mby_igr_pkg::CNT_W-1:0]                            i_rx_nw,
  input logic [mby_igr_pkg::N_SEGS-1:0][mby_igr_pkg::N_LANES-1:0] i_seg_we,
  input logic [mby_igr_pkg::N_SEGS-1:0]                           i_seg_e
);
  import mby_igr_pkg::*;

  // segments that take at least one word this cycle
  logic [N_SEGS-1:0] seg_wr;

  // number of failed assertions so far
  int fail_cnt = 0;

  always_comb begin
    for (int g = 0; g < N_SEGS; g++) begin
      seg_wr[g] = |i_seg_we[g];
    end
  end

  // one cycle carries at most eight words, which reach two segments at most
  a_no_triple_e: assert property (@(posedge cclk) disable iff (i_reset) !(&i_seg_e))
    else begin
      $error("all three segments completed in the same cycle");
      fail_cnt++;
    end

  a_two_seg_wr: assert property (@(posedge cclk) disable iff (i_reset) $countones(seg_wr) <= 2)
    else begin
      $error("more than two segments written in one cycle");
      fail_cnt++;
    end

  // the strobes are one register behind the input cycle they place
  a_we_count: assert property (@(posedge cclk) disable iff (i_reset)
    $countones(i_seg_we) == ($past(i_rx_v) ? int'($past(i_rx_nw)) : 0))
    else begin
      $error("enabled slots differ from the input word count");
      fail_cnt++;
    end

endmodule

bind igr_epl_shim_ctl igr_epl_shim_checker u_chk (
  .cclk     (cclk),
  .i_reset  (i_reset),
  .i_rx_v   (i_rx_v),
  .i_rx_nw  (i_rx_nw),
  .i_seg_we (o_seg_we),
  .i_seg_e  (o_seg_e)
);

`default_nettype wire

//--- igr_epl_shim.sv
// top of the ingress shim between the Ethernet port logic and the packet buffer
`default_nettype none
`timescale 1ns/10ps

module igr_epl_shim (
  input  logic                                             cclk,
  input  logic                                             i_reset,
  input  logic                                             i_rx_v,
  input  logic                                             i_rx_sop,
  input  logic                                             i_rx_eop,
  input  logic [mby_igr_pkg::CNT_W-1:0]                    i_rx_nw,
  input  mby_igr_pkg::data64_t [mby_igr_pkg::N_LANES-1:0]   i_rx_data,
  input  mby_igr_pkg::epl_ts_t                             i_rx_ts,
  output mby_igr_pkg::data64_t [mby_igr_pkg::N_SEGS-1:0][mby_igr_pkg::N_LANES-1:0] o_pb_data,
  output mby_igr_pkg::seg_md_t [mby_igr_pkg::N_SEGS-1:0]   o_pb_md,
  output logic [mby_igr_pkg::N_SEGS-1:0]                   o_pb_v
);
  import mby_igr_pkg::*;

  // registered strobes from control to the segment bank
  lane_sel_t [N_SEGS-1:0][N_LANES-1:0] seg_sel;
  logic [N_SEGS-1:0][N_LANES-1:0]      seg_we;
  logic [N_SEGS-1:0]                   seg_start;
  logic [N_SEGS-1:0]                   seg_sop;
  logic [N_SEGS-1:0]                   seg_eop;
  logic [N_SEGS-1:0]                   seg_e;

  // control sees only the framing, the words go straight to the bank
  igr_epl_shim_ctl u_ctl (
    .cclk        (cclk),
    .i_reset     (i_reset),
    .i_rx_v      (i_rx_v),
    .i_rx_sop    (i_rx_sop),
    .i_rx_eop    (i_rx_eop),
    .i_rx_nw     (i_rx_nw),
    .o_seg_sel   (seg_sel),
    .o_seg_we    (seg_we),
    .o_seg_start (seg_start),
    .o_seg_sop   (seg_sop),
    .o_seg_eop   (seg_eop),
    .o_seg_e     (seg_e)
  );

  // bank output is two cycles behind the input cycle that closes a segment
  igr_epl_shim_segs u_segs (
    .cclk        (cclk),
    .i_reset     (i_reset),
    .i_rx_data   (i_rx_data),
    .i_rx_ts     (i_rx_ts),
    .i_seg_sel   (seg_sel),
    .i_seg_we    (seg_we),
    .i_seg_start (seg_start),
    .i_seg_sop   (seg_sop),
    .i_seg_eop   (seg_eop),
    .i_seg_e     (seg_e),
    .o_pb_data   (o_pb_data),
    .o_pb_md     (o_pb_md),
    .o_pb_v      (o_pb_v)
  );

endmodule

`default_nettype wire

//--- igr_epl_shim_segs.sv
// bank of three ingress shim segments with the input data stage and the packet buffer valid
`default_nettype none
`timescale 1ns/10ps

module igr_epl_shim_segs (
  input  logic                                             cclk,
  input  logic                                             i_reset,
  input  mby_igr_pkg::data64_t [mby_igr_pkg::N_LANES-1:0]   i_rx_data,
  input  mby_igr_pkg::epl_ts_t                             i_rx_ts,
  input  mby_igr_pkg::lane_sel_t [mby_igr_pkg::N_SEGS-1:0][mby_igr_pkg::N_LANES-1:0] i_seg_sel,
  input  logic [mby_igr_pkg::N_SEGS-1:0][mby_igr_pkg::N_LANES-1:0] i_seg_we,
  input  logic [mby_igr_pkg::N_SEGS-1:0]                   i_seg_start,
  input  logic [mby_igr_pkg::N_SEGS-1:0]                   i_seg_sop,
  input  logic [mby_igr_pkg::N_SEGS-1:0]                   i_seg_eop,
  input  logic [mby_igr_pkg::N_SEGS-1:0]                   i_seg_e,
  output mby_igr_pkg::data64_t [mby_igr_pkg::N_SEGS-1:0][mby_igr_pkg::N_LANES-1:0] o_pb_data,
  output mby_igr_pkg::seg_md_t [mby_igr_pkg::N_SEGS-1:0]   o_pb_md,
  output logic [mby_igr_pkg::N_SEGS-1:0]                   o_pb_v
);
  import mby_igr_pkg::*;

  // input words and timestamp one stage late, level with the control strobes
  data64_t [N_LANES-1:0] rx_data_q;
  epl_ts_t               rx_ts_q;

  // completion delayed so the valid follows the last segment write
  logic [N_SEGS-1:0]     pb_v_q;

  // ----------------------------------------
  // alignment stage
  // ----------------------------------------

  always_ff @(posedge cclk) begin
    rx_data_q <= i_rx_data;
    rx_ts_q   <= i_rx_ts;
  end

  // two bits may be set together, never all three
  always_ff @(posedge cclk) begin
    if (i_reset) begin
      pb_v_q <= '0;
    end else begin
      pb_v_q <= i_seg_e;
    end
  end

  assign o_pb_v = pb_v_q;

  // ----------------------------------------
  // segment registers
  // ----------------------------------------

  // a segment is written at the edge its completion is delayed, so data and valid meet
  for (genvar g = 0; g < N_SEGS; g++) begin : g_seg
    igr_epl_shim_seg u_seg (
      .cclk        (cclk),
      .i_reset     (i_reset),
      .i_rx_data   (rx_data_q),
      .i_rx_ts     (rx_ts_q),
      .i_seg_sel   (i_seg_sel[g]),
      .i_seg_we    (i_seg_we[g]),
      .i_seg_start (i_seg_start[g]),
      .i_seg_sop   (i_seg_sop[g]),
      .i_seg_eop   (i_seg_eop[g]),
      .o_seg_data  (o_pb_data[g]),
      .o_seg_md    (o_pb_md[g])
    );
  end

endmodule

`default_nettype wire

//--- igr_epl_shim_seg.sv
// one 64-byte segment register of the ingress shim with its metadata accumulator
`default_nettype none
`timescale 1ns/10ps

module igr_epl_shim_seg (
  input  logic                                             cclk,
  input  logic                                             i_reset,
  input  mby_igr_pkg::data64_t [mby_igr_pkg::N_LANES-1:0]   i_rx_data,
  input  mby_igr_pkg::epl_ts_t                             i_rx_ts,
  input  mby_igr_pkg::lane_sel_t [mby_igr_pkg::N_LANES-1:0] i_seg_sel,
  input  logic [mby_igr_pkg::N_LANES-1:0]                  i_seg_we,
  input  logic                                             i_seg_start,
  input  logic                                             i_seg_sop,
  input  logic                                             i_seg_eop,
  output mby_igr_pkg::data64_t [mby_igr_pkg::N_LANES-1:0]   o_seg_data,
  output mby_igr_pkg::seg_md_t                             o_seg_md
);
  import mby_igr_pkg::*;

  data64_t [N_LANES-1:0] seg_data;
  logic                  md_sop;
  logic                  md_eop;
  logic [CNT_W-1:0]      md_cnt;
  epl_ts_t               md_ts;

  // number of slots written this cycle
  logic [CNT_W-1:0]      we_cnt;

  // ----------------------------------------
  // data slots
  // ----------------------------------------

  // each enabled slot loads the lane named by its select, others hold
  always_ff @(posedge cclk) begin
    for (int s = 0; s < N_LANES; s++) begin
      if (i_seg_we[s]) begin
        seg_data[s] <= i_rx_data[i_seg_sel[s]];
      end
    end
  end

  // ----------------------------------------
  // metadata
  // ----------------------------------------

  always_comb begin
    we_cnt = '0;
    for (int s = 0; s < N_LANES; s++) begin
      we_cnt = we_cnt + CNT_W'(i_seg_we[s]);
    end
  end

  // a start restarts the count, and end of packet may arrive in the same cycle
  always_ff @(posedge cclk) begin
    if (i_reset) begin
      md_sop <= 1'b0;
      md_eop <= 1'b0;
      md_cnt <= '0;
    end else if (i_seg_start) begin
      md_sop <= i_seg_sop;
      md_eop <= i_seg_eop;
      md_cnt <= we_cnt;
    end else begin
      md_eop <= md_eop | i_seg_eop;
      md_cnt <= md_cnt + we_cnt;
    end
  end

  // timestamp of the cycle that carried the first word
  always_ff @(posedge cclk) begin
    if (i_seg_start) begin
      md_ts <= i_rx_ts;
    end
  end

  assign o_seg_data = seg_data;
  assign o_seg_md   = '{sop: md_sop, eop: md_eop, cnt: md_cnt, ts: md_ts};

endmodule

`default_nettype wire

//--- igr_epl_shim_ctl.sv
// ingress shim control that packs input words into segments and drives the segment bank strobes
`default_nettype none
`timescale 1ns/10ps

module igr_epl_shim_ctl (
  input  logic                                        cclk,
  input  logic                                        i_reset,
  input  logic                                        i_rx_v,
  input  logic                                        i_rx_sop,
  input  logic                                        i_rx_eop,
  input  logic [mby_igr_pkg::CNT_W-1:0]               i_rx_nw,
  output mby_igr_pkg::lane_sel_t [mby_igr_pkg::N_SEGS-1:0][mby_igr_pkg::N_LANES-1:0] o_seg_sel,
  output logic [mby_igr_pkg::N_SEGS-1:0][mby_igr_pkg::N_LANES-1:0] o_seg_we,
  output logic [mby_igr_pkg::N_SEGS-1:0]              o_seg_start,
  output logic [mby_igr_pkg::N_SEGS-1:0]              o_seg_sop,
  output logic [mby_igr_pkg::N_SEGS-1:0]              o_seg_eop,
  output logic [mby_igr_pkg::N_SEGS-1:0]              o_seg_e
);
  import mby_igr_pkg::*;

  // round-robin successor of a segment index
  function automatic logic [SEG_W-1:0] seg_inc(input logic [SEG_W-1:0] idx);
    seg_inc = (idx == SEG_W'(N_SEGS - 1)) ? '0 : idx + 1'b1;
  endfunction

  // ----------------------------------------
  // pointer state
  // ----------------------------------------

  // segment being filled and the next free slot inside it
  logic [SEG_W-1:0] cur_seg;
  logic [CNT_W-1:0] cur_off;

  // a start-of-packet on a partly filled segment moves on to a fresh one
  logic [SEG_W-1:0] base_seg;
  logic [SEG_W-1:0] next_seg;
  logic [SEG_W-1:0] after_seg;
  logic [CNT_W-1:0] base_off;
  logic [CNT_W-1:0] end_off;
  logic [CNT_W-1:0] spill_off;
  logic             full;
  logic             spill;

  // next values of the registered strobes
  lane_sel_t [N_SEGS-1:0][N_LANES-1:0] nxt_sel;
  logic [N_SEGS-1:0][N_LANES-1:0]      nxt_we;
  logic [N_SEGS-1:0]                   nxt_start;
  logic [N_SEGS-1:0]                   nxt_sop;
  logic [N_SEGS-1:0]                   nxt_eop;
  logic [N_SEGS-1:0]                   nxt_e;

  assign base_seg  = (i_rx_sop && cur_off != '0) ? seg_inc(cur_seg) : cur_seg;
  assign next_seg  = seg_inc(base_seg);
  assign after_seg = seg_inc(next_seg);
  assign base_off  = i_rx_sop ? '0 : cur_off;

  // offset 7 plus eight words is 15, so the sum never wraps
  assign end_off   = base_off + i_rx_nw;
  assign full      = end_off >= CNT_W'(N_LANES);
  assign spill     = i_rx_v && (end_off > CNT_W'(N_LANES));
  assign spill_off = end_off - CNT_W'(N_LANES);

  // ----------------------------------------
  // slot placement
  // ----------------------------------------

  always_comb begin
    logic is_base;
    logic is_spill;
    for (int g = 0; g < N_SEGS; g++) begin
      is_base  = i_rx_v && (SEG_W'(g) == base_seg);
      is_spill = spill && (SEG_W'(g) == next_seg);
      for (int s = 0; s < N_LANES; s++) begin
        // slot s takes lane s - base_off, modulo eight also for the spilled part
        nxt_sel[g][s] = lane_sel_t'(CNT_W'(s) - base_off);
        nxt_we[g][s]  = (is_base && CNT_W'(s) >= base_off && CNT_W'(s) < end_off) ||
                        (is_spill && CNT_W'(s) < spill_off);
      end
      // a segment starts on its first write, offset zero or spill target
      nxt_start[g] = (is_base && base_off == '0) || is_spill;
      nxt_sop[g]   = is_base && i_rx_sop;
      // the last word of the packet sits in the spill segment when there is one
      nxt_eop[g]   = i_rx_eop && (spill ? is_spill : is_base);
      // the spill segment can only be closed by end of packet, it never reaches eight here
      nxt_e[g]     = (is_base && (full || i_rx_eop)) || (is_spill && i_rx_eop);
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge cclk) begin
    if (i_reset) begin
      cur_seg     <= '0;
      cur_off     <= '0;
      o_seg_we    <= '0;
      o_seg_start <= '0;
      o_seg_sop   <= '0;
      o_seg_eop   <= '0;
      o_seg_e     <= '0;
    end else begin
      o_seg_we    <= nxt_we;
      o_seg_start <= nxt_start;
      o_seg_sop   <= nxt_sop;
      o_seg_eop   <= nxt_eop;
      o_seg_e     <= nxt_e;
      if (i_rx_v) begin
        if (spill) begin
          cur_seg <= i_rx_eop ? after_seg : next_seg;
          cur_off <= i_rx_eop ? '0 : spill_off;
        end else if (full || i_rx_eop) begin
          cur_seg <= next_seg;
          cur_off <= '0;
        end else begin
          cur_seg <= base_seg;
          cur_off <= end_off;
        end
      end
    end
  end

  // lane selects only matter where a write enable is set
  always_ff @(posedge cclk) begin
    o_seg_sel <= nxt_sel;
  end

endmodule

`default_nettype wire

//--- mby_igr_pkg.sv
// shared widths, counts and types of the ingress shim, imported by every shim module
`default_nettype none

package mby_igr_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  // the port logic delivers up to eight words per cycle on lanes 0 to 7
  localparam int N_LANES = 8;

  // segment registers used round-robin toward the packet buffer
  localparam int N_SEGS = 3;

  // index width of a segment register
  localparam int SEG_W = 2;

  // width of one data word
  localparam int WORD_W = 64;

  // width of the port timestamp
  localparam int TS_W = 32;

  // a word count or word offset, wide enough for offset plus a full cycle (0 to 15)
  localparam int CNT_W = 4;

  // ----------------------------------------
  // types
  // ----------------------------------------

  // one 64-bit data word
  typedef logic [WORD_W-1:0] data64_t;

  // lane index feeding one slot of a segment
  typedef logic [2:0] lane_sel_t;

  // timestamp sampled by the port logic
  typedef logic [TS_W-1:0] epl_ts_t;

  // metadata of one 64-byte segment, 38 bits
  typedef struct packed {
    logic             sop;
    logic             eop;
    logic [CNT_W-1:0] cnt;
    epl_ts_t          ts;
  } seg_md_t;

endpackage

`default_nettype wire
